/* verilog/shifter_pkg.sv */
// raster constants, register map, shift modes, plane count helper and packed bus structs
`default_nettype none

package shifter_pkg;

	// --------------------------------------------------------------------
	// raster, one pixel per clock, display starts at hcnt 0 / vcnt 0
	// --------------------------------------------------------------------
	localparam logic [6:0] H_DISPLAY   = 7'd64;
	localparam logic [6:0] H_BORDER    = 7'd16;
	localparam logic [6:0] H_FRONT     = 7'd8;
	localparam logic [6:0] H_SYNC      = 7'd8;
	localparam logic [6:0] H_BACK      = 7'd8;
	localparam logic [6:0] H_TOTAL     = 7'd120;
	localparam logic [4:0] V_DISPLAY   = 5'd8;
	localparam logic [4:0] V_BORDER    = 5'd2;
	localparam logic [4:0] V_FRONT     = 5'd1;
	localparam logic [4:0] V_SYNC      = 5'd2;
	localparam logic [4:0] V_BACK      = 5'd1;
	localparam logic [4:0] V_TOTAL     = 5'd16;

	// memory fetch runs one 16 pixel group ahead of the display
	localparam logic [6:0] FETCH_AHEAD = 7'd16;
	localparam int ADDR_W = 23;
	localparam logic [ADDR_W-1:0] BASE_RESET = 23'h008000;
	localparam int PALETTE_ENTRIES = 16;

	// register word offsets on the apb side
	localparam logic [5:0] REG_BASE_HI     = 6'h00;
	localparam logic [5:0] REG_BASE_MID    = 6'h01;
	localparam logic [5:0] REG_BASE_LO     = 6'h02;
	localparam logic [5:0] REG_VADDR_HI    = 6'h03;
	localparam logic [5:0] REG_VADDR_MID   = 6'h04;
	localparam logic [5:0] REG_VADDR_LO    = 6'h05;
	localparam logic [5:0] REG_LINE_OFFSET = 6'h07;
	// 16 entries, 0x10 up to 0x1f
	localparam logic [5:0] REG_PALETTE     = 6'h10;
	localparam logic [5:0] REG_SHIFT_MODE  = 6'h20;

	typedef enum logic [1:0] {LOW_4P = 2'd0, MID_2P = 2'd1, MONO_1P = 2'd2} shift_mode_t;
	typedef enum logic [1:0] {RS_SYNC, RS_BLANK, RS_BORDER, RS_DISPLAY} raster_state_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} st_color_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [5:0] paddr;
		logic [15:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [15:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] base;
		logic [7:0] line_offset;
		shift_mode_t mode;
		st_color_t pal0;
	} shifter_cfg_t;

	typedef struct packed {
		logic [6:0] hcnt;
		logic [4:0] vcnt;
		raster_state_t h_state;
		raster_state_t v_state;
		logic hs;
		logic vs;
		logic fetch_en;
		logic frame_reload;
	} raster_t;

	typedef struct packed {
		logic read;
		logic [ADDR_W-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
		logic hs;
		logic vs;
		logic de;
	} video_t;

	// bitplanes per 16 pixel group for a shift mode
	function automatic logic [2:0] mode_planes(input shift_mode_t mode);
		case (mode)
			LOW_4P:  return 3'd4;
			MID_2P:  return 3'd2;
			default: return 3'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

/* verilog/plane_fetch.sv */
// bitplane fetch: read sequencer, video address counter and plane word latches
`timescale 1ns/1ps
`default_nettype none

module plane_fetch (
	input  wire logic                            clk,
	input  wire logic                            reg_reset,
	input  wire shifter_pkg::raster_t            raster,
	input  wire shifter_pkg::shifter_cfg_t       cfg,
	output      shifter_pkg::mem_req_t           mem_req,
	input  wire logic [15:0]                     mem_data,
	output      logic [shifter_pkg::ADDR_W-1:0]  vaddr,
	output      logic [3:0][15:0]                plane_words,
	output      logic                            words_ready
);
	import shifter_pkg::*;

	logic [3:0]        slot;
	logic [2:0]        planes;
	logic              issue;
	logic              fetch_en_q;
	logic              read_q;
	logic [ADDR_W-1:0] addr_q;
	logic [1:0]        req_plane;
	logic              data_valid;
	logic [1:0]        data_plane;

	assign planes = mode_planes(cfg.mode);

	// one read per plane at the start of each group
	assign issue = raster.fetch_en && (slot < {1'b0, planes});

	// last cycle of a group hands the words to the shifters
	assign words_ready = raster.fetch_en && (slot == 4'hf);

	// --------------------------------------------------------------------
	// slot counter, request pipe and video address
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			slot       <= 4'h0;
			fetch_en_q <= 1'b0;
			read_q     <= 1'b0;
			data_valid <= 1'b0;
			vaddr      <= BASE_RESET;
		end else begin
			// restarts at 0 whenever the window closes
			slot       <= raster.fetch_en ? slot + 4'h1 : 4'h0;
			fetch_en_q <= raster.fetch_en;
			read_q     <= issue;
			// memory answers one cycle after the read
			data_valid <= read_q;
			if (raster.frame_reload)
				vaddr <= cfg.base;
			else if (issue)
				vaddr <= vaddr + 23'd1;
			else if (fetch_en_q && !raster.fetch_en)
				// skip the line offset at the end of the fetched line
				vaddr <= vaddr + {15'h0000, cfg.line_offset};
		end
	end

	// address and plane tags travel with the request
	always_ff @(posedge clk) begin
		if (issue) begin
			addr_q    <= vaddr;
			req_plane <= slot[1:0];
		end
		data_plane <= req_plane;
		if (data_valid)
			plane_words[data_plane] <= mem_data;
	end

	assign mem_req = '{read: read_q, addr: addr_q};

endmodule

`default_nettype wire

/* verilog/pixel_engine.sv */
// pixel engine: plane shift registers, mono and palette colour, registered video output
`timescale 1ns/1ps
`default_nettype none

module pixel_engine (
	input  wire logic                            clk,
	input  wire logic                            reg_reset,
	input  wire shifter_pkg::raster_t            raster,
	input  wire shifter_pkg::shifter_cfg_t       cfg,
	output      shifter_pkg::mem_req_t           mem_req,
	input  wire logic [15:0]                     mem_data,
	output      logic [shifter_pkg::ADDR_W-1:0]  vaddr,
	output      logic [3:0]                      pal_index,
	input  wire shifter_pkg::st_color_t          pal_color,
	output      shifter_pkg::video_t             video
);
	import shifter_pkg::*;

	logic [3:0][15:0] plane_words;
	logic             words_ready;
	logic [3:0][15:0] shift_q;
	logic [2:0]       planes;
	logic             disp;
	logic             border;
	logic             mono_bit;
	st_color_t        pix;

	// memory sequencer and word latches
	plane_fetch u_fetch (
		.clk         (clk),
		.reg_reset   (reg_reset),
		.raster      (raster),
		.cfg         (cfg),
		.mem_req     (mem_req),
		.mem_data    (mem_data),
		.vaddr       (vaddr),
		.plane_words (plane_words),
		.words_ready (words_ready)
	);

	assign planes = mode_planes(cfg.mode);

	// --------------------------------------------------------------------
	// plane shifters, reload every 16 pixels
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (words_ready) begin
			shift_q[0] <= plane_words[0];
			// unused planes shift in zeros
			shift_q[1] <= (planes > 3'd1) ? plane_words[1] : 16'h0000;
			shift_q[2] <= (planes > 3'd2) ? plane_words[2] : 16'h0000;
			shift_q[3] <= (planes > 3'd2) ? plane_words[3] : 16'h0000;
		end else begin
			for (int i = 0; i < 4; i++)
				shift_q[i] <= {shift_q[i][14:0], 1'b0};
		end
	end

	// region of the current pixel
	assign disp   = (raster.h_state == RS_DISPLAY) && (raster.v_state == RS_DISPLAY);
	assign border = !disp && (raster.h_state inside {RS_BORDER, RS_DISPLAY}) &&
		(raster.v_state inside {RS_BORDER, RS_DISPLAY});

	// plane msbs form the index; border looks up entry 0
	assign pal_index = disp ? {shift_q[3][15], shift_q[2][15], shift_q[1][15], shift_q[0][15]}
		: 4'd0;

	// mono inverts through the lsb of entry 0
	assign mono_bit = shift_q[0][15] ^ cfg.pal0.b[0];

	always_comb begin
		if (disp) begin
			if (cfg.mode == MONO_1P)
				pix = mono_bit ? '{r: 3'd7, g: 3'd7, b: 3'd7} : '0;
			else
				pix = pal_color;
		end else if (border) begin
			pix = pal_color;
		end else begin
			// blank and sync are black
			pix = '0;
		end
	end

	// --------------------------------------------------------------------
	// output register, syncs ride along with their pixel
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset)
			video <= '0;
		else
			video <= '{r: pix.r, g: pix.g, b: pix.b, hs: raster.hs, vs: raster.vs, de: disp};
	end

endmodule

`default_nettype wire

/* verilog/raster_timing.sv */
// horizontal and vertical raster counters, region states, syncs and fetch window
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
	input  wire logic             clk,
	input  wire logic             reg_reset,
	output      shifter_pkg::raster_t raster
);
	import shifter_pkg::*;

	logic [6:0]    hcnt;
	logic [4:0]    vcnt;
	raster_state_t h_state;
	raster_state_t v_state;
	logic          next_disp_line;
	logic          fetch_en;
	logic          frame_reload;

	// --------------------------------------------------------------------
	// counters, vcnt steps when hcnt wraps
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == H_TOTAL - 7'd1) begin
			hcnt <= '0;
			if (vcnt == V_TOTAL - 5'd1)
				vcnt <= '0;
			else
				vcnt <= vcnt + 5'd1;
		end else begin
			hcnt <= hcnt + 7'd1;
		end
	end

	// display | border | front | sync | back | border
	always_comb begin
		if (hcnt < H_DISPLAY)
			h_state = RS_DISPLAY;
		else if (hcnt < H_DISPLAY + H_BORDER)
			h_state = RS_BORDER;
		else if (hcnt < H_DISPLAY + H_BORDER + H_FRONT)
			h_state = RS_BLANK;
		else if (hcnt < H_DISPLAY + H_BORDER + H_FRONT + H_SYNC)
			h_state = RS_SYNC;
		else if (hcnt < H_DISPLAY + H_BORDER + H_FRONT + H_SYNC + H_BACK)
			h_state = RS_BLANK;
		else
			h_state = RS_BORDER;
	end

	// same layout vertically, whole lines
	always_comb begin
		if (vcnt < V_DISPLAY)
			v_state = RS_DISPLAY;
		else if (vcnt < V_DISPLAY + V_BORDER)
			v_state = RS_BORDER;
		else if (vcnt < V_DISPLAY + V_BORDER + V_FRONT)
			v_state = RS_BLANK;
		else if (vcnt < V_DISPLAY + V_BORDER + V_FRONT + V_SYNC)
			v_state = RS_SYNC;
		else if (vcnt < V_DISPLAY + V_BORDER + V_FRONT + V_SYNC + V_BACK)
			v_state = RS_BLANK;
		else
			v_state = RS_BORDER;
	end

	// --------------------------------------------------------------------
	// fetch window
	// --------------------------------------------------------------------
	// the first group is fetched at the end of the previous line
	assign next_disp_line = (vcnt == V_TOTAL - 5'd1) || (vcnt < V_DISPLAY - 5'd1);

	// window is contiguous across the hcnt wrap, 4 groups long
	assign fetch_en = ((hcnt < H_DISPLAY - FETCH_AHEAD) && (vcnt < V_DISPLAY)) ||
		((hcnt >= H_TOTAL - FETCH_AHEAD) && next_disp_line);

	// first cycle of vertical sync
	assign frame_reload = (vcnt == V_DISPLAY + V_BORDER + V_FRONT) && (hcnt == 7'd0);

	assign raster = '{
		hcnt:         hcnt,
		vcnt:         vcnt,
		h_state:      h_state,
		v_state:      v_state,
		hs:           (h_state == RS_SYNC),
		vs:           (v_state == RS_SYNC),
		fetch_en:     fetch_en,
		frame_reload: frame_reload
	};

endmodule

`default_nettype wire

/* verilog/shifter_regs.sv */
// apb register file: video base, line offset, shift mode, palette and vaddr read-back
`timescale 1ns/1ps
`default_nettype none

module shifter_regs (
	input  wire logic                             clk,
	input  wire logic                             reg_reset,
	input  wire shifter_pkg::apb_req_t            apb_req,
	output      shifter_pkg::apb_rsp_t            apb_rsp,
	input  wire logic [shifter_pkg::ADDR_W-1:0]   vaddr,
	output      shifter_pkg::shifter_cfg_t        cfg,
	input  wire logic [3:0]                       pal_index,
	output      shifter_pkg::st_color_t           pal_color
);
	import shifter_pkg::*;

	logic [ADDR_W-1:0] base_q;
	logic [7:0]        line_offset_q;
	shift_mode_t       mode_q;
	st_color_t         palette_q [PALETTE_ENTRIES];

	logic        access;
	logic        is_palette;
	logic        mapped;
	logic        read_only;
	logic        bad_mode;
	logic        wr_err;
	logic        wr_ok;
	logic [3:0]  pal_sel;
	logic [15:0] rd_data;

	// --------------------------------------------------------------------
	// address decode and read mux
	// --------------------------------------------------------------------
	assign access     = apb_req.psel && apb_req.penable;
	assign is_palette = (apb_req.paddr[5:4] == REG_PALETTE[5:4]);
	assign pal_sel    = apb_req.paddr[3:0];

	always_comb begin
		mapped    = 1'b1;
		read_only = 1'b0;
		rd_data   = '0;
		if (is_palette) begin
			// 0RRR0GGG0BBB, each channel only 3 bits wide
			rd_data = {4'h0, 1'b0, palette_q[pal_sel].r, 1'b0, palette_q[pal_sel].g,
				1'b0, palette_q[pal_sel].b};
		end else begin
			case (apb_req.paddr)
				REG_BASE_HI:     rd_data = {8'h00, base_q[22:15]};
				REG_BASE_MID:    rd_data = {8'h00, base_q[14:7]};
				// low byte of the byte address, bit 0 always clear
				REG_BASE_LO:     rd_data = {8'h00, base_q[6:0], 1'b0};
				REG_VADDR_HI: begin
					rd_data   = {8'h00, vaddr[22:15]};
					read_only = 1'b1;
				end
				REG_VADDR_MID: begin
					rd_data   = {8'h00, vaddr[14:7]};
					read_only = 1'b1;
				end
				REG_VADDR_LO: begin
					rd_data   = {8'h00, vaddr[6:0], 1'b0};
					read_only = 1'b1;
				end
				REG_LINE_OFFSET: rd_data = {8'h00, line_offset_q};
				REG_SHIFT_MODE:  rd_data = {6'h00, mode_q, 8'h00};
				default:         mapped  = 1'b0;
			endcase
		end
	end

	// mode 3 is reserved and refused
	assign bad_mode = (apb_req.paddr == REG_SHIFT_MODE) && (apb_req.pwdata[9:8] == 2'd3);
	assign wr_err   = !mapped || read_only || bad_mode;
	assign wr_ok    = access && apb_req.pwrite && !wr_err;

	// no wait states, every access phase completes at once
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access && (apb_req.pwrite ? wr_err : !mapped);
	assign apb_rsp.prdata  = (access && !apb_req.pwrite && mapped) ? rd_data : 16'h0000;

	// --------------------------------------------------------------------
	// register writes, visible on the next clock
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			base_q        <= BASE_RESET;
			line_offset_q <= 8'h00;
			mode_q        <= MONO_1P;
			// entry 0 blue, all others black
			for (int i = 0; i < PALETTE_ENTRIES; i++)
				palette_q[i] <= (i == 0) ? 9'h007 : 9'h000;
		end else if (wr_ok) begin
			if (is_palette) begin
				palette_q[pal_sel] <= '{r: apb_req.pwdata[10:8], g: apb_req.pwdata[6:4],
					b: apb_req.pwdata[2:0]};
			end else begin
				case (apb_req.paddr)
					// hi or mid write clears the low byte, as on the ST
					REG_BASE_HI:     base_q <= {apb_req.pwdata[7:0], base_q[14:7], 7'h00};
					REG_BASE_MID:    base_q <= {base_q[22:15], apb_req.pwdata[7:0], 7'h00};
					REG_BASE_LO:     base_q[6:0] <= apb_req.pwdata[7:1];
					REG_LINE_OFFSET: line_offset_q <= apb_req.pwdata[7:0];
					REG_SHIFT_MODE:  mode_q <= shift_mode_t'(apb_req.pwdata[9:8]);
					default: ;
				endcase
			end
		end
	end

	// config out to the pixel side
	assign cfg = '{base: base_q, line_offset: line_offset_q, mode: mode_q,
		pal0: palette_q[0]};

	// combinational palette port for the pixel engine
	assign pal_color = palette_q[pal_index];

endmodule

`default_nettype wire

/* verilog/st_shifter.sv */
// top level of the video shifter: register file, raster timing and pixel engine
`timescale 1ns/1ps
`default_nettype none

module st_shifter (
	input  wire logic                   clk,
	input  wire logic                   reg_reset,
	// cpu side, apb slave
	input  wire shifter_pkg::apb_req_t  apb_req,
	output      shifter_pkg::apb_rsp_t  apb_rsp,
	// video memory, data one cycle after read
	output      shifter_pkg::mem_req_t  mem_req,
	input  wire logic [15:0]            mem_data,
	// registered pixel stream with syncs
	output      shifter_pkg::video_t    video
);
	import shifter_pkg::*;

	// --------------------------------------------------------------------
	// internal wiring
	// --------------------------------------------------------------------
	shifter_cfg_t      cfg;
	raster_t           raster;
	logic [ADDR_W-1:0] vaddr;
	logic [3:0]        pal_index;
	st_color_t         pal_color;

	// cpu registers and palette
	shifter_regs u_regs (
		.clk       (clk),
		.reg_reset (reg_reset),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.vaddr     (vaddr),
		.cfg       (cfg),
		.pal_index (pal_index),
		.pal_color (pal_color)
	);

	// fixed raster counters
	raster_timing u_timing (
		.clk       (clk),
		.reg_reset (reg_reset),
		.raster    (raster)
	);

	// fetch, shift and colour lookup
	pixel_engine u_pixel (
		.clk       (clk),
		.reg_reset (reg_reset),
		.raster    (raster),
		.cfg       (cfg),
		.mem_req   (mem_req),
		.mem_data  (mem_data),
		.vaddr     (vaddr),
		.pal_index (pal_index),
		.pal_color (pal_color),
		.video     (video)
	);

endmodule

`default_nettype wire

/* testbench/st_shifter_asserts.sv */
// concurrent checks on the apb response, blank region colour and hs pulse width
`timescale 1ns/1ps
`default_nettype none

module st_shifter_asserts (
	input wire logic                   clk,
	input wire logic                   reg_reset,
	input wire shifter_pkg::apb_req_t  apb_req,
	input wire shifter_pkg::apb_rsp_t  apb_rsp,
	input wire shifter_pkg::raster_t   raster,
	input wire shifter_pkg::video_t    video
);
	import shifter_pkg::*;

	// failures seen so far, read back by the testbench at the end
	int   assert_fails = 0;
	logic blank_now;

	// blank or sync, horizontally or vertically
	assign blank_now = (raster.h_state == RS_BLANK) || (raster.h_state == RS_SYNC) ||
		(raster.v_state == RS_BLANK) || (raster.v_state == RS_SYNC);

	// zero wait states on the apb side
	pready_in_access: assert property (@(posedge clk) disable iff (reg_reset)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
	else begin
		$error("pready low in an apb access phase");
		assert_fails++;
	end

	// output register lags the raster by one cycle
	blank_is_black: assert property (@(posedge clk) disable iff (reg_reset)
		blank_now |=> (!video.de && video.r == 3'd0 && video.g == 3'd0 && video.b == 3'd0))
	else begin
		$error("colour or de set in a blank region");
		assert_fails++;
	end

	hs_width: assert property (@(posedge clk) disable iff (reg_reset)
		$rose(video.hs) |-> video.hs [*H_SYNC] ##1 !video.hs)
	else begin
		$error("hs pulse width differs from H_SYNC");
		assert_fails++;
	end

endmodule

bind st_shifter st_shifter_asserts u_asserts (
	.clk       (clk),
	.reg_reset (reg_reset),
	.apb_req   (apb_req),
	.apb_rsp   (apb_rsp),
	.raster    (raster),
	.video     (video)
);

`default_nettype wire

/* testbench/tb_st_shifter.sv */
// testbench: clock, reset, apb driver, memory model, frame checker, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module tb_st_shifter;
	import shifter_pkg::*;

	localparam int FRAME     = int'(H_TOTAL) * int'(V_TOTAL);
	localparam int DE_PIXELS = int'(V_DISPLAY) * int'(H_DISPLAY);
	localparam int MAX_ROWS  = 64;

	logic              clk;
	logic              reg_reset;
	apb_req_t          apb_req;
	apb_rsp_t          apb_rsp;
	mem_req_t          mem_req;
	logic [15:0]       mem_data;
	video_t            video;

	logic [31:0]       cmd [0:4*MAX_ROWS-1];
	st_color_t         pal [PALETTE_ENTRIES];
	logic              pend_read;
	logic [ADDR_W-1:0] pend_addr;
	int                n_scen;
	bit                loaded;
	int                de_seen;
	int                err_apb;
	int                err_video;
	int                err_vaddr;
	int                err_count;

	st_shifter dut (
		.clk       (clk),
		.reg_reset (reg_reset),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.mem_req   (mem_req),
		.mem_data  (mem_data),
		.video     (video)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// memory model, data one cycle after the read is seen
	// ----------------------------------------------------------------------
	function automatic logic [15:0] mem_word(input logic [ADDR_W-1:0] addr);
		logic [31:0] h;
		h = {9'h000, addr} * 32'h9e3779b1;
		h = h ^ (h >> 13);
		return h[15:0];
	endfunction

	initial begin
		forever begin
			@(posedge clk);
			#2;
			mem_data = pend_read ? mem_word(pend_addr) : 16'h0000;
			pend_read = mem_req.read;
			pend_addr = mem_req.addr;
		end
	end

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_apb(input apb_rsp_t got, input apb_rsp_t exp, input logic [5:0] addr);
		if (got !== exp) begin
			err_apb++;
			$display("FAIL @%0t: apb offset %h got data %h rdy %b err %b, expected %h %b %b",
				$time, addr, got.prdata, got.pready, got.pslverr,
				exp.prdata, exp.pready, exp.pslverr);
		end
	endtask

	task automatic check_video(input video_t got, input video_t exp, input int h, input int v);
		if (got !== exp) begin
			err_video++;
			$display("FAIL @%0t: video line %0d pixel %0d got %h expected %h",
				$time, v, h, got, exp);
		end
	endtask

	task automatic check_vaddr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
		if (got !== exp) begin
			err_vaddr++;
			$display("FAIL @%0t: video address got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			err_count++;
			$display("FAIL @%0t: %s count %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// apb driver, setup then access, inputs 2 ns after the edge
	// ----------------------------------------------------------------------
	task automatic apb_access(input logic [5:0] addr, input logic wr, input logic [15:0] wdata,
		output apb_rsp_t rsp);
		@(posedge clk);
		#2;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk);
		#2;
		apb_req.penable = 1'b1;
		// response is stable mid cycle
		@(negedge clk);
		rsp = apb_rsp;
		@(posedge clk);
		#2;
		apb_req = '0;
	endtask

	task automatic reg_write(input logic [5:0] addr, input logic [15:0] data, input logic err);
		apb_rsp_t rsp;
		apb_rsp_t exp;
		apb_access(addr, 1'b1, data, rsp);
		exp.prdata  = 16'h0000;
		exp.pready  = 1'b1;
		exp.pslverr = err;
		check_apb(rsp, exp, addr);
	endtask

	task automatic reg_read(input logic [5:0] addr, input logic [15:0] data, input logic err);
		apb_rsp_t rsp;
		apb_rsp_t exp;
		apb_access(addr, 1'b0, 16'h0000, rsp);
		exp.prdata  = err ? 16'h0000 : data;
		exp.pready  = 1'b1;
		exp.pslverr = err;
		check_apb(rsp, exp, addr);
	endtask

	// ----------------------------------------------------------------------
	// reference raster: display 0..63, border, front, sync, back, border
	// ----------------------------------------------------------------------
	function automatic video_t expect_pixel(input int h, input int v, input logic [1:0] mode,
		input logic [ADDR_W-1:0] base, input logic [7:0] off);
		video_t            e;
		int                planes;
		int                bitpos;
		logic [3:0]        idx;
		logic [15:0]       w;
		logic [ADDR_W-1:0] line_start;
		logic              hvis;
		logic              vvis;
		e    = '0;
		hvis = (h < H_DISPLAY + H_BORDER) || (h >= H_TOTAL - H_BORDER);
		vvis = (v < V_DISPLAY + V_BORDER) || (v >= V_TOTAL - V_BORDER);
		e.hs = (h >= H_DISPLAY + H_BORDER + H_FRONT) && (h < H_DISPLAY + H_BORDER + H_FRONT + H_SYNC);
		e.vs = (v >= V_DISPLAY + V_BORDER + V_FRONT) && (v < V_DISPLAY + V_BORDER + V_FRONT + V_SYNC);
		if (h < H_DISPLAY && v < V_DISPLAY) begin
			e.de   = 1'b1;
			planes = (mode == 2'd0) ? 4 : (mode == 2'd1) ? 2 : 1;
			// words of a line, planes interleaved per 16 pixel group
			line_start = base + ADDR_W'(v * (planes * int'(H_DISPLAY) / 16 + int'(off)));
			bitpos     = 15 - (h % 16);
			idx        = 4'h0;
			for (int p = 0; p < planes; p++) begin
				w      = mem_word(line_start + ADDR_W'((h / 16) * planes + p));
				idx[p] = w[bitpos];
			end
			if (mode == 2'd2) begin
				if (idx[0] ^ pal[0].b[0])
					{e.r, e.g, e.b} = 9'h1ff;
			end else begin
				{e.r, e.g, e.b} = pal[idx];
			end
		end else if (hvis && vvis) begin
			{e.r, e.g, e.b} = pal[0];
		end
		return e;
	endfunction

	// next rising edge of vs, the first output sample of a frame
	task automatic wait_frame_start();
		logic last;
		last = 1'b1;
		@(negedge clk);
		while (!(video.vs && !last)) begin
			last = video.vs;
			@(negedge clk);
		end
	endtask

	// ----------------------------------------------------------------------
	// one frame scenario: program, wait for reload, check a whole frame
	// ----------------------------------------------------------------------
	task automatic run_frame(input logic [1:0] mode, input logic [ADDR_W-1:0] base,
		input logic [7:0] off, input int n);
		logic [15:0]       wd;
		logic [ADDR_W-1:0] exp_vaddr;
		apb_rsp_t          r_hi;
		apb_rsp_t          r_mid;
		apb_rsp_t          r_lo;
		int                h;
		int                v;
		int                hs_pulses;
		int                vs_pulses;
		int                vs_cycles;
		logic              last_hs;
		logic              last_vs;
		for (int i = 0; i < PALETTE_ENTRIES; i++) begin
			wd = 16'($urandom);
			// entry 0 lsb alternates, so mono frames flip
			if (i == 0)
				wd[0] = n[0];
			pal[i] = {wd[10:8], wd[6:4], wd[2:0]};
			reg_write(REG_PALETTE + 6'(i), wd, 1'b0);
		end
		reg_write(REG_SHIFT_MODE, {6'h00, mode, 8'h00}, 1'b0);
		reg_write(REG_BASE_HI, {8'h00, base[22:15]}, 1'b0);
		reg_write(REG_BASE_MID, {8'h00, base[14:7]}, 1'b0);
		reg_write(REG_BASE_LO, {8'h00, base[6:0], 1'b0}, 1'b0);
		reg_write(REG_LINE_OFFSET, {8'h00, off}, 1'b0);
		exp_vaddr = base + ADDR_W'(int'(V_DISPLAY) * (((mode == 2'd0) ? 4 : (mode == 2'd1) ? 2 : 1)
			* int'(H_DISPLAY) / 16 + int'(off)));
		wait_frame_start();
		de_seen   = 0;
		hs_pulses = 0;
		vs_pulses = 0;
		vs_cycles = 0;
		last_hs   = 1'b0;
		last_vs   = 1'b0;
		h         = 0;
		v         = int'(V_DISPLAY + V_BORDER + V_FRONT);
		fork
			begin
				for (int k = 0; k < FRAME; k++) begin
					if (k > 0)
						@(negedge clk);
					check_video(video, expect_pixel(h, v, mode, base, off), h, v);
					if (video.de)
						de_seen++;
					if (video.hs && !last_hs)
						hs_pulses++;
					if (video.vs && !last_vs)
						vs_pulses++;
					if (video.vs)
						vs_cycles++;
					last_hs = video.hs;
					last_vs = video.vs;
					h++;
					if (h == int'(H_TOTAL)) begin
						h = 0;
						v = (v + 1) % int'(V_TOTAL);
					end
				end
			end
			begin
				// last display line done, reload still ahead
				wait (de_seen == DE_PIXELS);
				apb_access(REG_VADDR_HI, 1'b0, 16'h0000, r_hi);
				apb_access(REG_VADDR_MID, 1'b0, 16'h0000, r_mid);
				apb_access(REG_VADDR_LO, 1'b0, 16'h0000, r_lo);
				check_vaddr({r_hi.prdata[7:0], r_mid.prdata[7:0], r_lo.prdata[7:1]}, exp_vaddr);
			end
		join
		check_count(de_seen, DE_PIXELS, "de pixel");
		check_count(hs_pulses, int'(V_TOTAL), "hs pulse");
		check_count(vs_pulses, 1, "vs pulse");
		check_count(vs_cycles, int'(V_SYNC) * int'(H_TOTAL), "vs cycle");
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int row;
		int scen;
		int total;
		reg_reset = 1'b1;
		apb_req   = '0;
		mem_data  = 16'h0000;
		pend_read = 1'b0;
		pend_addr = '0;
		de_seen   = 0;
		err_apb   = 0;
		err_video = 0;
		err_vaddr = 0;
		err_count = 0;
		n_scen    = 0;
		scen      = 0;
		void'($urandom(32'h75632891));
		for (int i = 0; i < 4 * MAX_ROWS; i++)
			cmd[i] = 32'h0;
		$readmemh("testbench/shifter_input.txt", cmd);
		for (int i = 0; i < MAX_ROWS && cmd[4*i] != 0; i++)
			if (cmd[4*i] == 3)
				n_scen++;
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		reg_reset = 1'b0;
		row = 0;
		while (row < MAX_ROWS && cmd[4*row] != 0) begin
			case (cmd[4*row])
				1: reg_write(cmd[4*row+1][5:0], cmd[4*row+2][15:0], cmd[4*row+3][0]);
				2: reg_read(cmd[4*row+1][5:0], cmd[4*row+2][15:0], cmd[4*row+3][0]);
				3: begin
					run_frame(cmd[4*row+1][1:0], cmd[4*row+2][ADDR_W-1:0], cmd[4*row+3][7:0], scen);
					scen++;
				end
				default: begin
					err_count++;
					$display("unknown command kind %h in input row %0d", cmd[4*row], row);
				end
			endcase
			row++;
		end
		if (row == 0) begin
			err_count++;
			$display("no commands were read from the input file");
		end
		total = err_apb + err_video + err_vaddr + err_count + dut.u_asserts.assert_fails;
		$display("errors: apb %0d video %0d vaddr %0d count %0d assertion %0d",
			err_apb, err_video, err_vaddr, err_count, dut.u_asserts.assert_fails);
		if (total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// three frames per scenario, at least one
	initial begin
		longint limit;
		wait (loaded);
		limit = longint'((n_scen > 0) ? n_scen : 1) * 3 * FRAME * 40;
		#(limit);
		$display("watchdog: the run did not finish within its time limit");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
verilog/shifter_pkg.sv
verilog/plane_fetch.sv
verilog/pixel_engine.sv
verilog/raster_timing.sv
verilog/shifter_regs.sv
verilog/st_shifter.sv
testbench/st_shifter_asserts.sv
testbench/tb_st_shifter.sv

/* testbench/shifter_input.txt */
// kind, then three hex fields; kind 1 write: offset data pslverr, kind 2 read: offset rdata pslverr
// kind 3 frame: mode base_word_addr line_offset, kind 0 ends the list
1 02 00fe 0
2 02 00fe 0
1 00 0012 0
2 00 0012 0
2 02 0000 0
1 01 0034 0
2 01 0034 0
1 07 0005 0
2 07 0005 0
1 13 0fff 0
2 13 0777 0
1 20 0100 0
1 20 0300 1
2 20 0100 0
1 04 0055 1
1 06 1234 1
2 06 0000 1
2 3f 0000 1
3 0 004000 0
3 1 004100 3
3 2 006000 0
3 2 006000 2
0 0 0 0
